// File: Bender.yml
package:
  name: ap_instr

sources:
  # shared packages
  - common/ap_isa_pkg.sv
  - common/ap_mem_pkg.sv
  # design
  - ins_cache/isa_burst_reader.sv
  - ins_cache/ins_cache.sv
  - hdl/program_counter.sv
  - hdl/ap_instr_top.sv
  # testbench
  - target: test
    files:
      - verification/ap_instr_tb.sv

// File: common/ap_isa_pkg.sv
package ap_isa_pkg;

    //////////////////////////////
    // instruction field types
    //////////////////////////////

    typedef logic [3:0]  opcode_t;
    typedef logic [7:0]  cam_addr_t;         // row or column address inside the CAM
    typedef logic [1:0]  operand2_t;
    typedef logic [15:0] mem_addr_t;         // word address of an instruction

    //////////////////////////////
    // opcodes
    //////////////////////////////

    localparam opcode_t RESET    = 4'd1;
    localparam opcode_t RET      = 4'd2;     // last instruction of a program
    localparam opcode_t LOADRBR  = 4'd4;
    localparam opcode_t LOADCBC  = 4'd5;
    localparam opcode_t STORERBR = 4'd6;
    localparam opcode_t STORECBC = 4'd7;
    localparam opcode_t COPY     = 4'd8;
    localparam opcode_t ADD      = 4'd9;
    localparam opcode_t SUB      = 4'd10;
    localparam opcode_t TSC      = 4'd11;
    localparam opcode_t ABS      = 4'd12;

    // operand 2 selects one of the CAM fields
    localparam operand2_t M_A = 2'd1;
    localparam operand2_t M_B = 2'd2;
    localparam operand2_t M_R = 2'd3;

    //////////////////////////////
    // instruction word
    //////////////////////////////

    typedef struct packed {
        opcode_t   opcode;
        cam_addr_t cam_addr;
        operand2_t operand2;
        mem_addr_t mem_addr;
    } ap_instr_t;                            // 30 bits, opcode in the top nibble

endpackage

// File: common/ap_mem_pkg.sv
package ap_mem_pkg;

    import ap_isa_pkg::mem_addr_t;

    //////////////////////////////
    // DDR side widths
    //////////////////////////////

    typedef logic [27:0] ddr_addr_t;         // byte address on the DDR port
    typedef logic [9:0]  burst_len_t;        // refill length and received word count

    //////////////////////////////
    // cache and program sizes
    //////////////////////////////

    localparam burst_len_t CACHE_DEPTH     = 10'd32;   // words held in one block
    localparam mem_addr_t  TOTAL_ISA_DEPTH = 16'd128;  // words of program space
    localparam ddr_addr_t  DDR_WORD_BYTES  = 28'd8;    // each instruction sits in a 64 bit slot

    typedef logic [$clog2(CACHE_DEPTH)-1:0] cache_idx_t;

endpackage

// File: hdl/ap_instr_top.sv
`timescale 1ns/1ps

module ap_instr_top
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      start,
    input  mem_addr_t start_addr,

    // external memory read port
    output logic      mem_rd_en,
    output ddr_addr_t mem_rd_addr,
    input  ap_instr_t mem_rd_data,

    // processor controller side
    output ap_instr_t instruction,
    output logic      ins_valid,
    output logic      halted
);

    logic       fetch;
    mem_addr_t  fetch_addr;

    logic       refill_req;
    ddr_addr_t  refill_addr;
    burst_len_t refill_len;
    logic       word_valid;
    ap_instr_t  word_data;
    burst_len_t word_cnt;
    logic       refill_done;

    program_counter u_pc (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_addr  (start_addr),
        .ins_valid   (ins_valid),
        .instruction (instruction),
        .fetch       (fetch),
        .fetch_addr  (fetch_addr),
        .halted      (halted)
    );

    ins_cache u_cache (
        .clk         (clk),
        .rst         (rst),
        .fetch       (fetch),
        .fetch_addr  (fetch_addr),
        .instruction (instruction),
        .ins_valid   (ins_valid),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_len  (refill_len),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .word_cnt    (word_cnt),
        .refill_done (refill_done)
    );

    isa_burst_reader u_burst (
        .clk         (clk),
        .rst         (rst),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_len  (refill_len),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .word_valid  (word_valid),
        .word_data   (word_data),
        .word_cnt    (word_cnt),
        .refill_done (refill_done)
    );

endmodule

// File: hdl/program_counter.sv
`timescale 1ns/1ps

module program_counter
    import ap_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      start,
    input  mem_addr_t start_addr,

    input  logic      ins_valid,
    input  ap_instr_t instruction,

    output logic      fetch,
    output mem_addr_t fetch_addr,
    output logic      halted
);

    typedef enum logic {
        pc_idle,
        pc_run
    } pc_state_t;

    pc_state_t state_q;
    logic      fetch_q;
    mem_addr_t addr_q;
    logic      halted_q;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q  <= pc_idle;
            fetch_q  <= 1'b0;
            addr_q   <= '0;
            halted_q <= 1'b0;
        end
        else if (start)
        begin
            state_q  <= pc_run;
            fetch_q  <= 1'b1;
            addr_q   <= start_addr;
            halted_q <= 1'b0;
        end
        else
        begin
            fetch_q <= 1'b0;
            if (state_q == pc_run && ins_valid)
            begin
                if (instruction.opcode == RET)
                begin
                    state_q  <= pc_idle;
                    halted_q <= 1'b1;               // held until the next start
                end
                else
                begin
                    addr_q  <= addr_q + 1'b1;
                    fetch_q <= 1'b1;
                end
            end
        end
    end

    assign fetch      = fetch_q;
    assign fetch_addr = addr_q;
    assign halted     = halted_q;

    // once halted, only a new start brings fetches back
    a_no_fetch_halted : assert property (@(posedge clk) disable iff (!rst)
        halted && !start |=> !fetch);

endmodule

// File: ins_cache/ins_cache.sv
`timescale 1ns/1ps

module ins_cache
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // program counter side
    input  logic       fetch,
    input  mem_addr_t  fetch_addr,

    // processor controller side
    output ap_instr_t  instruction,
    output logic       ins_valid,

    // burst reader side
    output logic       refill_req,
    output ddr_addr_t  refill_addr,
    output burst_len_t refill_len,
    input  logic       word_valid,
    input  ap_instr_t  word_data,
    input  burst_len_t word_cnt,
    input  logic       refill_done
);

    typedef enum logic [1:0] {
        idle,
        load_ins,
        sent_ins
    } cache_state_t;

    cache_state_t state_q;

    ap_instr_t    cache_mem [0:CACHE_DEPTH-1];
    ap_instr_t    instr_q;
    mem_addr_t    tag_q;
    burst_len_t   fill_len_q;
    logic         filled_q;
    logic         refill_req_q;
    ddr_addr_t    refill_addr_q;

    mem_addr_t    offset;
    mem_addr_t    remain;
    burst_len_t   clip_len;
    logic         hit;

    //////////////////////////////
    // tag window compare
    //////////////////////////////

    assign offset   = fetch_addr - tag_q;
    assign remain   = TOTAL_ISA_DEPTH - fetch_addr;
    assign clip_len = (remain > mem_addr_t'(CACHE_DEPTH)) ? CACHE_DEPTH : burst_len_t'(remain);

    assign hit = filled_q
              && (fetch_addr >= tag_q)
              && (offset < mem_addr_t'(fill_len_q));   // the block may be short near the top

    //////////////////////////////
    // control state
    //////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q      <= idle;
            tag_q        <= '0;
            fill_len_q   <= '0;
            filled_q     <= 1'b0;
            refill_req_q <= 1'b0;
        end
        else
        begin
            refill_req_q <= 1'b0;
            case (state_q)
                idle:
                begin
                    if (fetch)
                    begin
                        if (hit)
                        begin
                            state_q <= sent_ins;
                        end
                        else
                        begin
                            state_q      <= load_ins;
                            refill_req_q <= 1'b1;
                            tag_q        <= fetch_addr;      // the missed word starts the block
                            fill_len_q   <= clip_len;
                            filled_q     <= 1'b0;           // old contents are overwritten in place
                        end
                    end
                end

                load_ins:
                begin
                    if (refill_done)
                    begin
                        state_q  <= sent_ins;
                        filled_q <= 1'b1;
                    end
                end

                sent_ins:
                begin
                    state_q <= idle;
                end

                default:
                begin
                    state_q <= idle;
                end
            endcase
        end
    end

    // byte address of the block start, captured on a miss
    always_ff @(posedge clk)
    begin
        if (state_q == idle && fetch && !hit)
        begin
            refill_addr_q <= ddr_addr_t'(fetch_addr) * DDR_WORD_BYTES;
        end
    end

    //////////////////////////////
    // block array and output
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (state_q == load_ins && word_valid)
        begin
            cache_mem[cache_idx_t'(word_cnt - 1'b1)] <= word_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == idle && fetch && hit)
        begin
            instr_q <= cache_mem[cache_idx_t'(offset)];
        end
        else if (state_q == load_ins && word_valid && word_cnt == burst_len_t'(1))
        begin
            instr_q <= word_data;                   // first word of a refill is the missed one
        end
    end

    assign instruction = instr_q;
    assign ins_valid   = (state_q == sent_ins);
    assign refill_req  = refill_req_q;
    assign refill_addr = refill_addr_q;
    assign refill_len  = fill_len_q;

    // returned words belong to a refill that this cache asked for
    a_word_in_load : assert property (@(posedge clk) disable iff (!rst)
        word_valid |-> state_q == load_ins);

    // the burst reader never hands back more words than requested
    a_cnt_bound : assert property (@(posedge clk) disable iff (!rst)
        word_valid |-> word_cnt <= refill_len);

endmodule

// File: ins_cache/isa_burst_reader.sv
`timescale 1ns/1ps

module isa_burst_reader
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // request from the cache
    input  logic       refill_req,
    input  ddr_addr_t  refill_addr,
    input  burst_len_t refill_len,

    // memory read port
    output logic       mem_rd_en,
    output ddr_addr_t  mem_rd_addr,
    input  ap_instr_t  mem_rd_data,

    // returned words
    output logic       word_valid,
    output ap_instr_t  word_data,
    output burst_len_t word_cnt,
    output logic       refill_done
);

    logic       rd_en_q;
    logic       rd_en_d_q;
    ddr_addr_t  rd_addr_q;
    burst_len_t rd_left_q;
    burst_len_t len_q;
    burst_len_t rcv_cnt_q;

    //////////////////////////////
    // read issue and return count
    //////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_en_q   <= 1'b0;
            rd_en_d_q <= 1'b0;
            rd_left_q <= '0;
            rcv_cnt_q <= '0;
        end
        else
        begin
            rd_en_d_q <= rd_en_q;                   // memory answers one cycle after the read
            if (refill_req)
            begin
                rd_en_q   <= (refill_len != '0);
                rd_left_q <= refill_len;
                rcv_cnt_q <= '0;
            end
            else
            begin
                if (rd_en_q)
                begin
                    rd_left_q <= rd_left_q - 1'b1;
                    if (rd_left_q == burst_len_t'(1))
                    begin
                        rd_en_q <= 1'b0;            // last read of the burst
                    end
                end
                if (word_valid)
                begin
                    rcv_cnt_q <= rcv_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_req)
        begin
            rd_addr_q <= refill_addr;
            len_q     <= refill_len;
        end
        else if (rd_en_q)
        begin
            rd_addr_q <= rd_addr_q + DDR_WORD_BYTES;
        end
    end

    assign mem_rd_en   = rd_en_q;
    assign mem_rd_addr = rd_addr_q;
    assign word_valid  = rd_en_d_q;
    assign word_data   = mem_rd_data;
    assign word_cnt    = rcv_cnt_q + 1'b1;       // counts from 1 with the word it marks
    assign refill_done = word_valid && (word_cnt == len_q);

    // the cache waits for refill_done before it can miss again
    a_no_req_busy : assert property (@(posedge clk) disable iff (!rst)
        refill_req |-> !(rd_en_q || rd_en_d_q));

endmodule

// File: src.f
common/ap_isa_pkg.sv
common/ap_mem_pkg.sv
ins_cache/isa_burst_reader.sv
ins_cache/ins_cache.sv
hdl/program_counter.sv
hdl/ap_instr_top.sv
verification/ap_instr_tb.sv

// File: verification/ap_instr_tb.sv
`timescale 1ns/1ps

module ap_instr_tb
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
();

    localparam int PROG_WORDS     = 71 + 18 + 8;    // instructions delivered over all runs
    localparam int TIMEOUT_CYCLES = 4 * PROG_WORDS * (int'(CACHE_DEPTH) + 4);

    logic      clk;
    logic      rst;
    logic      start;
    mem_addr_t start_addr;
    logic      mem_rd_en;
    ddr_addr_t mem_rd_addr;
    ap_instr_t mem_rd_data;
    ap_instr_t instruction;
    logic      ins_valid;
    logic      halted;

    ap_instr_t prog_mem [0:TOTAL_ISA_DEPTH-1];
    logic [15:0] lfsr = 16'd36342;
    int        cycle_cnt = 0;

    // run bookkeeping, written by the monitor while a program runs
    mem_addr_t run_start = '0;
    int        exp_idx = 0;
    int        blk_cnt = 0;
    int        cur_len = 0;
    int        prev_valid_cyc = -1;
    logic      burst_since = 1'b0;
    logic      rd_en_prev = 1'b0;
    ddr_addr_t last_rd_addr = '0;
    int        burst_starts [$];
    int        burst_lens [$];
    int        blk_deliv [$];

    ap_instr_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_addr  (start_addr),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .instruction (instruction),
        .ins_valid   (ins_valid),
        .halted      (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // reference and helpers
    //////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 16'hB400;                       // taps 16 14 13 11
        end
        return n;
    endfunction

    // the n-th delivered instruction of a run is the program word at start plus n
    function automatic ap_instr_t expected_instr(input mem_addr_t from, input int idx);
        return prog_mem[int'(from) + idx];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic fill_program();
        ap_instr_t w;
        for (int a = 0; a < int'(TOTAL_ISA_DEPTH); a++)
        begin
            for (int b = 0; b < $bits(ap_instr_t); b++)
            begin
                lfsr = lfsr_step(lfsr);
                w[b] = lfsr[0];
            end
            if (w.opcode == RET)
            begin
                w.opcode = ADD;                     // programs end only where a test puts RET
            end
            prog_mem[a] = w;
        end
    endtask

    task automatic run_program(input mem_addr_t addr, input int exp_len);
        run_start  = addr;
        exp_idx    = 0;
        blk_cnt    = 0;
        burst_starts.delete();
        burst_lens.delete();
        blk_deliv.delete();
        start      <= 1'b1;
        start_addr <= addr;
        @(posedge clk);
        start <= 1'b0;
        do
            @(posedge clk);
        while (!halted);
        repeat (8) @(posedge clk);                  // nothing may be delivered after RET
        check_value("delivered count", exp_idx, exp_len);
        check_value("halted", halted, 1);
    endtask

    task automatic check_burst(input int idx, input int exp_start, input int exp_len);
        check_value("burst start word", burst_starts[idx], exp_start);
        check_value("burst length", burst_lens[idx], exp_len);
    endtask

    task automatic check_blocks();
        for (int i = 0; i < blk_deliv.size(); i++)
        begin
            check_value("delivered per block", blk_deliv[i], burst_lens[i]);
        end
        check_value("last block within burst", blk_cnt <= burst_lens[burst_lens.size()-1], 1);
    endtask

    //////////////////////////////
    // memory model and monitor
    //////////////////////////////

    always @(posedge clk)
    begin
        if (mem_rd_en)
        begin
            mem_rd_data <= prog_mem[mem_rd_addr / DDR_WORD_BYTES];
        end
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (start)
            begin
                prev_valid_cyc = -1;
            end
            if (mem_rd_en && !rd_en_prev)
            begin
                // a burst must fetch the word the program counter is waiting for
                check_value("burst address", mem_rd_addr,
                            (int'(run_start) + exp_idx) * int'(DDR_WORD_BYTES));
                if (burst_starts.size() > 0)
                begin
                    blk_deliv.push_back(blk_cnt);
                end
                blk_cnt = 0;
                cur_len = 0;
                burst_starts.push_back(int'(mem_rd_addr / DDR_WORD_BYTES));
            end
            else if (mem_rd_en)
            begin
                check_value("burst address step", mem_rd_addr, last_rd_addr + DDR_WORD_BYTES);
            end
            if (!mem_rd_en && rd_en_prev)
            begin
                burst_lens.push_back(cur_len);
            end
            if (mem_rd_en)
            begin
                cur_len++;
                burst_since  = 1'b1;
                last_rd_addr = mem_rd_addr;
            end
            if (ins_valid)
            begin
                check_value("instruction", instruction, expected_instr(run_start, exp_idx));
                if (prev_valid_cyc >= 0 && !burst_since)
                begin
                    check_value("hit spacing", cycle_cnt - prev_valid_cyc, 2);
                end
                prev_valid_cyc = cycle_cnt;
                burst_since    = 1'b0;
                exp_idx++;
                blk_cnt++;
            end
            rd_en_prev = mem_rd_en;
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Simulation failed");
            $fatal(1, "timeout, the programs did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        rst         = 1'b0;
        start       = 1'b0;
        start_addr  = '0;
        mem_rd_data = '0;
        fill_program();
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        // sequential run through three blocks
        prog_mem[70].opcode = RET;
        run_program(16'd0, 71);
        check_value("burst count", burst_starts.size(), 3);
        check_burst(0, 0, 32);
        check_burst(1, 32, 32);
        check_burst(2, 64, 32);
        check_blocks();

        // block clipped at the top of program space
        prog_mem[70].opcode  = ADD;
        prog_mem[127].opcode = RET;
        run_program(16'd110, 18);
        check_value("burst count", burst_starts.size(), 1);
        check_burst(0, 110, 18);
        check_blocks();

        // restart below the current tag
        prog_mem[127].opcode = ADD;
        prog_mem[12].opcode  = RET;
        run_program(16'd5, 8);
        check_value("burst count", burst_starts.size(), 1);
        check_burst(0, 5, 32);
        check_blocks();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
